// ==== rtl/wisc_isa_pkg.sv ====
// WISC instruction set
package wisc_isa_pkg;

	typedef logic [15:0] word_t;
	typedef logic [3:0]  reg_idx_t;

	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_AND = 4'd2,
		OP_NOR = 4'd3,
		OP_SLL = 4'd4,
		OP_SRL = 4'd5,
		OP_SRA = 4'd6,
		OP_LW  = 4'd8,
		OP_SW  = 4'd9,
		OP_LHB = 4'd10,
		OP_LLB = 4'd11,
		OP_B   = 4'd12,
		OP_HLT = 4'd15
	} opcode_e; // Unlisted codes decode as no-ops

	typedef enum logic [2:0] {
		COND_NE = 3'd0, // Z clear
		COND_EQ = 3'd1, // Z set
		COND_GT = 3'd2, // Z and N clear
		COND_LT = 3'd3, // N set
		COND_GE = 3'd4, // N clear
		COND_LE = 3'd5, // Z or N set
		COND_OV = 3'd6, // V set
		COND_UN = 3'd7  // Always
	} cond_e;

	typedef struct packed {
		logic z; // Zero
		logic n; // Negative
		logic v; // Signed overflow
	} flags_t;

	typedef struct packed {
		opcode_e  opcode;
		reg_idx_t rd;
		reg_idx_t rs;
		reg_idx_t rt; // Also imm4 for shifts and LW/SW
	} r_view_t;

	typedef struct packed {
		opcode_e    opcode;
		reg_idx_t   rd;
		logic [7:0] imm8; // LLB/LHB byte
	} i_view_t;

	typedef struct packed {
		opcode_e    opcode;
		cond_e      cond;
		logic [8:0] off9; // Signed, relative to pc + 1
	} b_view_t;

	typedef union packed {
		r_view_t r_view;
		i_view_t i_view;
		b_view_t b_view;
	} instr_u;

endpackage

// ==== rtl/wisc_pipe_pkg.sv ====
// WISC pipeline records
package wisc_pipe_pkg;

	// Word address widths of the two memories
	localparam int IMEM_AW = 8;
	localparam int DMEM_AW = 8;

	// Fetch register, 33 bits
	typedef struct packed {
		logic                 valid;
		wisc_isa_pkg::word_t  pc;
		wisc_isa_pkg::instr_u instr;
	} fetch_out_t;

	// Decode register
	typedef struct packed {
		logic                   valid;
		wisc_isa_pkg::opcode_e  op;
		wisc_isa_pkg::cond_e    cond;
		wisc_isa_pkg::reg_idx_t rd;
		logic                   rd_we;   // Instruction writes rd
		wisc_isa_pkg::word_t    op_a;    // Value of rs
		wisc_isa_pkg::word_t    op_b;    // Value of rt
		wisc_isa_pkg::word_t    st_data; // Value of rd, SW data and LLB/LHB base
		wisc_isa_pkg::word_t    imm;     // Extended per opcode
		wisc_isa_pkg::word_t    pc_next;
	} decode_out_t;

	// Execute register
	typedef struct packed {
		logic                   valid;
		logic                   halt;
		logic                   reg_we;
		logic                   mem_rd;
		logic                   mem_wr;
		wisc_isa_pkg::reg_idx_t rd;
		wisc_isa_pkg::word_t    alu_result; // Also the data address
		wisc_isa_pkg::word_t    st_data;
	} exec_out_t;

	// Register write-back, 21 bits
	typedef struct packed {
		logic                   valid;
		wisc_isa_pkg::reg_idx_t rd;
		wisc_isa_pkg::word_t    data;
	} wb_event_t;

endpackage

// ==== rtl/fetch_unit.sv ====
// WISC fetch stage
`timescale 1ns/1ps

module fetch_unit (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 stall,
	input  logic                                 redirect,
	input  wisc_isa_pkg::word_t                  redirect_pc,
	input  logic                                 load_en,
	input  logic [wisc_pipe_pkg::IMEM_AW-1:0]    load_addr,
	input  wisc_isa_pkg::word_t                  load_word,
	output wisc_pipe_pkg::fetch_out_t            out
);
	import wisc_isa_pkg::*;
	import wisc_pipe_pkg::*;

	word_t imem [2**IMEM_AW];
	word_t pc;
	word_t fetched;

	assign fetched = imem[pc[IMEM_AW-1:0]]; // PC wraps within the memory

	// Load port, usable in any cycle
	always_ff @(posedge clk) begin
		if (load_en) begin
			imem[load_addr] <= load_word;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc        <= '0;
			out.valid <= 1'b0;
		end else if (redirect) begin
			pc        <= redirect_pc;
			out.valid <= 1'b0; // Squash the word fetched behind the branch
		end else if (!stall) begin
			out.valid <= 1'b1;
			out.pc    <= pc;
			out.instr <= instr_u'(fetched);
			pc        <= pc + 16'd1;
		end
	end

endmodule

// ==== rtl/decode_unit.sv ====
// WISC decode stage
`timescale 1ns/1ps

module decode_unit (
	input  logic                       clk,
	input  logic                       rst,
	input  wisc_pipe_pkg::fetch_out_t  in,
	input  logic                       redirect,
	input  wisc_pipe_pkg::wb_event_t   wb,
	input  wisc_pipe_pkg::exec_out_t   mem_stage,
	output logic                       stall,
	output wisc_pipe_pkg::decode_out_t out
);
	import wisc_isa_pkg::*;
	import wisc_pipe_pkg::*;

	word_t       regs [16]; // Entry 0 is never written
	logic        halt_q;
	opcode_e     op;
	reg_idx_t    rd;
	reg_idx_t    rs;
	reg_idx_t    rt;
	logic        use_rs;
	logic        use_rt;
	logic        use_rd;
	logic        hazard;
	decode_out_t nxt;

	// Register read with same-cycle write-back bypass
	function automatic word_t read_reg(input reg_idx_t idx);
		word_t val;
		if (idx == '0) begin
			val = '0;
		end else if (wb.valid && wb.rd == idx) begin
			val = wb.data;
		end else begin
			val = regs[idx];
		end
		return val;
	endfunction

	// Pending write in execute or memory
	function automatic logic busy(input reg_idx_t idx);
		logic ex_hit;
		logic mem_hit;
		ex_hit  = out.valid && out.rd_we && out.rd == idx;
		mem_hit = mem_stage.valid && mem_stage.reg_we && mem_stage.rd == idx;
		return idx != '0 && (ex_hit || mem_hit);
	endfunction

	always_comb begin
		op = in.instr.r_view.opcode;
		rd = in.instr.r_view.rd;
		rs = in.instr.r_view.rs;
		rt = in.instr.r_view.rt;
		use_rs = 1'b0;
		use_rt = 1'b0;
		use_rd = 1'b0;
		nxt.rd_we = 1'b0;
		nxt.imm = {{12{rt[3]}}, rt}; // imm4, shifts use only the low bits
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_NOR: begin
				use_rs = 1'b1;
				use_rt = 1'b1;
				nxt.rd_we = 1'b1;
			end
			OP_SLL, OP_SRL, OP_SRA, OP_LW: begin
				use_rs = 1'b1;
				nxt.rd_we = 1'b1;
			end
			OP_SW: begin
				use_rs = 1'b1;
				use_rd = 1'b1; // Store data
			end
			OP_LLB, OP_LHB: begin
				use_rd = 1'b1; // Merge base
				nxt.rd_we = 1'b1;
				nxt.imm = {8'h00, in.instr.i_view.imm8};
			end
			OP_B: nxt.imm = {{7{in.instr.b_view.off9[8]}}, in.instr.b_view.off9};
			default: ;
		endcase
		hazard = (use_rs && busy(rs)) || (use_rt && busy(rt)) || (use_rd && busy(rd));
		stall = halt_q || (in.valid && hazard); // Halted core holds fetch for good
		nxt.valid = in.valid && !stall && !redirect;
		nxt.op = op;
		nxt.cond = in.instr.b_view.cond;
		nxt.rd = rd;
		nxt.op_a = read_reg(rs);
		nxt.op_b = read_reg(rt);
		nxt.st_data = read_reg(rd);
		nxt.pc_next = in.pc + 16'd1;
	end

	always_ff @(posedge clk) begin
		if (wb.valid && wb.rd != '0) begin
			regs[wb.rd] <= wb.data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			halt_q    <= 1'b0;
			out.valid <= 1'b0;
		end else begin
			if (nxt.valid && op == OP_HLT) begin
				halt_q <= 1'b1; // Sticky until reset
			end
			out <= nxt; // Bubble when nxt.valid is low
		end
	end

endmodule

// ==== rtl/execute_unit.sv ====
// WISC execute stage
`timescale 1ns/1ps

module execute_unit (
	input  logic                       clk,
	input  logic                       rst,
	input  wisc_pipe_pkg::decode_out_t in,
	output logic                       redirect,
	output wisc_isa_pkg::word_t        redirect_pc,
	output wisc_pipe_pkg::exec_out_t   out
);
	import wisc_isa_pkg::*;
	import wisc_pipe_pkg::*;

	flags_t    flags;
	flags_t    flags_nxt;
	logic      set_flags;
	word_t     result;
	exec_out_t nxt;

	function automatic logic cond_met(input cond_e cond, input flags_t f);
		logic met;
		case (cond)
			COND_NE: met = !f.z;
			COND_EQ: met = f.z;
			COND_GT: met = !f.z && !f.n;
			COND_LT: met = f.n;
			COND_GE: met = !f.n;
			COND_LE: met = f.z || f.n;
			COND_OV: met = f.v;
			default: met = 1'b1; // UN
		endcase
		return met;
	endfunction

	always_comb begin
		result = '0;
		set_flags = 1'b0;
		flags_nxt = flags;
		case (in.op)
			OP_ADD: begin
				result = in.op_a + in.op_b;
				flags_nxt.v = in.op_a[15] == in.op_b[15] && result[15] != in.op_a[15];
				set_flags = 1'b1;
			end
			OP_SUB: begin
				result = in.op_a - in.op_b;
				flags_nxt.v = in.op_a[15] != in.op_b[15] && result[15] != in.op_a[15];
				set_flags = 1'b1;
			end
			OP_AND: begin
				result = in.op_a & in.op_b;
				flags_nxt.v = 1'b0;
				set_flags = 1'b1;
			end
			OP_NOR: begin
				result = ~(in.op_a | in.op_b);
				flags_nxt.v = 1'b0;
				set_flags = 1'b1;
			end
			OP_SLL: result = in.op_a << in.imm[3:0];
			OP_SRL: result = in.op_a >> in.imm[3:0];
			OP_SRA: result = $signed(in.op_a) >>> in.imm[3:0];
			OP_LW, OP_SW: result = in.op_a + in.imm; // Data address
			OP_LLB: result = {in.st_data[15:8], in.imm[7:0]};
			OP_LHB: result = {in.imm[7:0], in.st_data[7:0]};
			default: ;
		endcase
		flags_nxt.z = result == '0;
		flags_nxt.n = result[15];
		redirect = in.valid && in.op == OP_B && cond_met(in.cond, flags);
		redirect_pc = in.pc_next + in.imm;
		nxt.valid = in.valid;
		nxt.halt = in.op == OP_HLT;
		nxt.reg_we = in.rd_we;
		nxt.mem_rd = in.op == OP_LW;
		nxt.mem_wr = in.op == OP_SW;
		nxt.rd = in.rd;
		nxt.alu_result = result;
		nxt.st_data = in.st_data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			flags     <= '0;
			out.valid <= 1'b0;
		end else begin
			if (in.valid && set_flags) begin
				flags <= flags_nxt; // Seen by a branch in the next cycle
			end
			out <= nxt;
		end
	end

endmodule

// ==== rtl/memory_unit.sv ====
// WISC memory and write-back stage
`timescale 1ns/1ps

module memory_unit (
	input  logic                     clk,
	input  logic                     rst,
	input  wisc_pipe_pkg::exec_out_t in,
	output wisc_pipe_pkg::wb_event_t wb,
	output logic                     halted
);
	import wisc_isa_pkg::*;
	import wisc_pipe_pkg::*;

	word_t              dmem [2**DMEM_AW];
	logic [DMEM_AW-1:0] addr;
	wb_event_t          nxt;

	assign addr = in.alu_result[DMEM_AW-1:0]; // Word address wraps

	always_ff @(posedge clk) begin
		if (in.valid && in.mem_wr) begin
			dmem[addr] <= in.st_data;
		end
	end

	always_comb begin
		nxt.valid = in.valid && in.reg_we && in.rd != '0; // r0 writes vanish here
		nxt.rd = in.rd;
		nxt.data = in.mem_rd ? dmem[addr] : in.alu_result;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wb.valid <= 1'b0;
			halted   <= 1'b0;
		end else begin
			wb     <= nxt;
			halted <= halted || (in.valid && in.halt); // Same edge as its wb slot
		end
	end

endmodule

// ==== rtl/wisc_core.sv ====
// WISC pipelined core
`timescale 1ns/1ps

module wisc_core (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              load_en,
	input  logic [wisc_pipe_pkg::IMEM_AW-1:0] load_addr,
	input  wisc_isa_pkg::word_t               load_word,
	output wisc_pipe_pkg::wb_event_t          wb,
	output logic                              halted
);
	import wisc_isa_pkg::*;
	import wisc_pipe_pkg::*;

	fetch_out_t  fetch_out;
	decode_out_t decode_out;
	exec_out_t   exec_out;
	logic        stall;       // From decode, hazard or halt
	logic        redirect;    // Taken branch in execute
	word_t       redirect_pc;

	fetch_unit u_fetch (
		.clk         (clk),
		.rst         (rst),
		.stall       (stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.load_en     (load_en),
		.load_addr   (load_addr),
		.load_word   (load_word),
		.out         (fetch_out)
	);

	decode_unit u_decode (
		.clk       (clk),
		.rst       (rst),
		.in        (fetch_out),
		.redirect  (redirect),
		.wb        (wb),       // Register file write port
		.mem_stage (exec_out),
		.stall     (stall),
		.out       (decode_out)
	);

	execute_unit u_execute (
		.clk         (clk),
		.rst         (rst),
		.in          (decode_out),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.out         (exec_out)
	);

	memory_unit u_memory (
		.clk    (clk),
		.rst    (rst),
		.in     (exec_out),
		.wb     (wb),
		.halted (halted)
	);

endmodule

// ==== tests/wisc_core_asserts.sv ====
// WISC core pipeline checks
`timescale 1ns/1ps

module wisc_core_asserts (
	input logic                       clk,
	input logic                       rst,
	input wisc_pipe_pkg::wb_event_t   wb,
	input logic                       halted,
	input logic                       redirect,
	input logic                       stall,
	input wisc_pipe_pkg::decode_out_t decode_out
);
	import wisc_pipe_pkg::*;

	// Nothing retires once HLT has passed
	a_no_wb_after_halt: assert property (@(posedge clk) disable iff (rst)
		halted |-> !wb.valid)
		else $error("write-back seen while halted");

	a_redirect_pulse: assert property (@(posedge clk) disable iff (rst)
		redirect |=> !redirect)
		else $error("redirect held longer than one cycle");

	a_halted_sticky: assert property (@(posedge clk) disable iff (rst)
		halted |=> halted)
		else $error("halted fell without reset");

	// Halted core issues only bubbles
	a_halt_bubbles: assert property (@(posedge clk) disable iff (rst)
		(stall && halted) |-> !decode_out.valid)
		else $error("valid decode output while halted");

endmodule

bind wisc_core wisc_core_asserts u_asserts (
	.clk        (clk),
	.rst        (rst),
	.wb         (wb),
	.halted     (halted),
	.redirect   (redirect),
	.stall      (stall),
	.decode_out (decode_out)
);

// ==== tests/wisc_core_tb.sv ====
// WISC core testbench
`timescale 1ns/1ps

module wisc_core_tb;
	import wisc_isa_pkg::*;
	import wisc_pipe_pkg::*;

	logic               clk;
	logic               rst;
	logic               load_en;
	logic [IMEM_AW-1:0] load_addr;
	word_t              load_word;
	wb_event_t          wb;
	logic               halted;

	word_t       image [256]; // Program image, loaded whole each run
	int          plen;
	logic [19:0] exp_q [$];   // {rd, data} predicted by the model
	logic [19:0] got_q [$];
	int          errors;
	int          checks;

	wisc_core dut (
		.clk       (clk),
		.rst       (rst),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_word (load_word),
		.wb        (wb),
		.halted    (halted)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	function automatic word_t r_word(input opcode_e op, input int rd, input int rs, input int rt);
		return {op, rd[3:0], rs[3:0], rt[3:0]};
	endfunction

	function automatic word_t i_word(input opcode_e op, input int rd, input int imm8);
		return {op, rd[3:0], imm8[7:0]};
	endfunction

	function automatic word_t b_word(input int cond, input int off9);
		return {OP_B, cond[2:0], off9[8:0]};
	endfunction

	task automatic emit(input word_t w);
		image[plen] = w;
		plen++;
	endtask

	task automatic set_reg(input int rd, input word_t val);
		emit(i_word(OP_LLB, rd, val[7:0]));
		emit(i_word(OP_LHB, rd, val[15:8]));
	endtask

	// HLT everywhere, low byte tagged with the address, then clear r1..r15
	task automatic start_program();
		for (int a = 0; a < 256; a++) begin
			image[a] = {4'hF, 4'h0, a[7:0]};
		end
		plen = 0;
		for (int r = 1; r < 16; r++) begin
			emit(r_word(OP_AND, r, 0, 0));
		end
	endtask

	// Sequential reference of the instruction set
	task automatic model_run();
		word_t      regs [16];
		word_t      dmem [256];
		word_t      pc;
		word_t      w;
		word_t      a;
		word_t      b;
		word_t      r;
		word_t      imm4;
		logic [7:0] addr;
		logic [3:0] op;
		logic [3:0] rd;
		logic       z;
		logic       n;
		logic       v;
		logic       we;
		logic       taken;
		for (int i = 0; i < 16; i++) begin
			regs[i] = '0;
		end
		pc = '0;
		{z, n, v} = 3'b000;
		exp_q.delete();
		for (int steps = 0; steps < 1000; steps++) begin
			w = image[pc[7:0]];
			op = w[15:12];
			rd = w[11:8];
			a = regs[w[7:4]];
			b = regs[w[3:0]];
			imm4 = {{12{w[3]}}, w[3:0]};
			addr = 8'(a + imm4);
			we = 1'b1;
			r = '0;
			pc = pc + 16'd1;
			if (op == OP_HLT) begin
				break;
			end
			case (op)
				OP_ADD: begin
					r = a + b;
					v = a[15] == b[15] && r[15] != a[15];
				end
				OP_SUB: begin
					r = a - b;
					v = a[15] != b[15] && r[15] != a[15];
				end
				OP_AND: begin
					r = a & b;
					v = 1'b0;
				end
				OP_NOR: begin
					r = ~(a | b);
					v = 1'b0;
				end
				OP_SLL: r = a << w[3:0];
				OP_SRL: r = a >> w[3:0];
				OP_SRA: r = word_t'($signed(a) >>> w[3:0]);
				OP_LW: r = dmem[addr];
				OP_SW: begin
					dmem[addr] = regs[rd];
					we = 1'b0;
				end
				OP_LLB: r = {regs[rd][15:8], w[7:0]};
				OP_LHB: r = {w[7:0], regs[rd][7:0]};
				OP_B: begin
					case (w[11:9])
						3'd0: taken = !z;
						3'd1: taken = z;
						3'd2: taken = !z && !n;
						3'd3: taken = n;
						3'd4: taken = !n;
						3'd5: taken = z || n;
						3'd6: taken = v;
						default: taken = 1'b1;
					endcase
					if (taken) begin
						pc = pc + {{7{w[8]}}, w[8:0]};
					end
					we = 1'b0;
				end
				default: we = 1'b0; // Unused codes
			endcase
			if (op <= 4'd3) begin
				z = r == '0;
				n = r[15];
			end
			if (we && rd != 4'd0) begin
				regs[rd] = r;
				exp_q.push_back({rd, r});
			end
		end
	endtask

	// Reset, load, run to halt and compare with the model
	task automatic run_program(input string name);
		int cycles;
		int n;
		model_run();
		got_q.delete();
		rst = 1'b1;
		for (int i = 0; i < 256; i++) begin
			@(posedge clk);
			#1;
			load_en = 1'b1;
			load_addr = i[7:0];
			load_word = image[i];
		end
		@(posedge clk);
		#1;
		load_en = 1'b0;
		for (int i = 0; i < 16; i++) begin
			@(posedge clk);
			#1;
		end
		rst = 1'b0;
		cycles = 0;
		while (!halted && cycles < 3000) begin
			@(posedge clk);
			#1;
			if (wb.valid) begin
				got_q.push_back({wb.rd, wb.data});
			end
			cycles++;
		end
		if (!halted) begin
			$display("%s: core did not halt within %0d cycles", name, cycles);
			errors++;
		end
		for (int i = 0; i < 10; i++) begin // Quiet after halt
			@(posedge clk);
			#1;
			if (wb.valid) begin
				$display("%s: write-back to r%0d after halt", name, wb.rd);
				errors++;
			end
			if (!halted) begin
				$display("%s: halted dropped without reset", name);
				errors++;
			end
		end
		checks++;
		if (got_q.size() != exp_q.size()) begin
			$display("MISMATCH %s write-back count: expected %0d actual %0d", name,
				exp_q.size(), got_q.size());
			errors++;
		end
		n = got_q.size() < exp_q.size() ? got_q.size() : exp_q.size();
		for (int i = 0; i < n; i++) begin
			checks++;
			if (got_q[i] !== exp_q[i]) begin
				$display("MISMATCH %s event %0d: expected r%0d=%h actual r%0d=%h", name, i,
					exp_q[i][19:16], exp_q[i][15:0], got_q[i][19:16], got_q[i][15:0]);
				errors++;
			end
		end
	endtask

	task automatic test_arith();
		start_program();
		for (int r = 1; r <= 4; r++) begin
			set_reg(r, word_t'($urandom));
		end
		emit(r_word(OP_ADD, 5, 1, 2));
		emit(r_word(OP_SUB, 6, 1, 2));
		emit(r_word(OP_AND, 7, 3, 4));
		emit(r_word(OP_NOR, 8, 3, 4));
		emit(r_word(OP_ADD, 0, 1, 2)); // Dropped write
		emit(r_word(OP_SUB, 9, 3, 4));
		emit(r_word(OP_NOR, 0, 1, 1));
		emit(r_word(OP_HLT, 0, 0, 0));
		run_program("arith");
	endtask

	task automatic test_hazard();
		start_program();
		set_reg(1, word_t'($urandom));
		set_reg(2, word_t'($urandom));
		emit(r_word(OP_ADD, 3, 1, 2));
		emit(r_word(OP_ADD, 4, 3, 1));
		emit(r_word(OP_SUB, 5, 4, 3));
		emit(r_word(OP_AND, 6, 5, 4));
		emit(r_word(OP_NOR, 7, 6, 6));
		emit(r_word(OP_SLL, 8, 7, 3));
		emit(r_word(OP_ADD, 8, 8, 8));
		emit(i_word(OP_LLB, 8, 8'h5A)); // Merge into a just-written register
		emit(r_word(OP_HLT, 0, 0, 0));
		run_program("hazard");
	endtask

	task automatic test_shift();
		int amt [4] = '{0, 1, 7, 15};
		start_program();
		set_reg(1, word_t'($urandom) | 16'h8000); // Negative for SRA
		for (int i = 0; i < 4; i++) begin
			emit(r_word(OP_SLL, 2, 1, amt[i]));
			emit(r_word(OP_SRL, 3, 1, amt[i]));
			emit(r_word(OP_SRA, 4, 1, amt[i]));
		end
		set_reg(5, word_t'($urandom));
		emit(i_word(OP_LLB, 5, 8'hC3));
		emit(i_word(OP_LHB, 5, 8'h3C));
		emit(r_word(OP_HLT, 0, 0, 0));
		run_program("shift");
	endtask

	task automatic test_memory();
		start_program();
		set_reg(1, {8'h00, 8'($urandom)}); // Base address
		for (int r = 2; r <= 4; r++) begin
			set_reg(r, word_t'($urandom));
		end
		emit(r_word(OP_SW, 2, 1, 3));
		emit(r_word(OP_SW, 3, 1, -2));
		emit(r_word(OP_SW, 4, 1, 7));
		emit(r_word(OP_LW, 5, 1, 3));
		emit(r_word(OP_LW, 6, 1, -2));
		emit(r_word(OP_LW, 7, 1, 7));
		emit(r_word(OP_SW, 2, 1, -8));
		emit(r_word(OP_LW, 8, 1, -8)); // Store then load back to back
		emit(r_word(OP_HLT, 0, 0, 0));
		run_program("memory");
	endtask

	task automatic test_branch();
		int mark;
		start_program();
		mark = 1;
		set_reg(1, word_t'($urandom));
		set_reg(2, 16'h0001);
		set_reg(3, 16'h7000);
		for (int c = 0; c < 8; c++) begin
			for (int s = 0; s < 4; s++) begin
				case (s)
					0: emit(r_word(OP_SUB, 5, 1, 1)); // Zero
					1: emit(r_word(OP_SUB, 5, 0, 2)); // Negative
					2: emit(r_word(OP_ADD, 5, 3, 3)); // Overflow
					default: emit(r_word(OP_ADD, 5, 2, 2)); // Positive
				endcase
				emit(b_word(c, 2));
				emit(i_word(OP_LLB, 9, mark));
				emit(i_word(OP_LLB, 10, mark + 1));
				mark += 2;
			end
		end
		emit(r_word(OP_HLT, 0, 0, 0));
		run_program("branch");
	endtask

	task automatic test_halt();
		start_program();
		set_reg(1, word_t'($urandom));
		emit(r_word(OP_ADD, 2, 1, 1));
		emit(r_word(OP_HLT, 0, 0, 0));
		emit(i_word(OP_LLB, 3, 8'h55)); // Behind HLT, never written
		emit(i_word(OP_LLB, 4, 8'hAA));
		run_program("halt_first");
		start_program();
		set_reg(6, word_t'($urandom));
		emit(r_word(OP_SUB, 7, 6, 1));
		emit(r_word(OP_SRA, 8, 6, 2));
		emit(r_word(OP_HLT, 0, 0, 0));
		run_program("halt_reload");
	endtask

	initial begin
		rst = 1'b1;
		load_en = 1'b0;
		load_addr = '0;
		load_word = '0;
		errors = 0;
		checks = 0;
		void'($urandom(74806));
		test_arith();
		test_hazard();
		test_shift();
		test_memory();
		test_branch();
		test_halt();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== list.f ====
rtl/wisc_isa_pkg.sv
rtl/wisc_pipe_pkg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/memory_unit.sv
rtl/wisc_core.sv
tests/wisc_core_asserts.sv
tests/wisc_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and fail if the log reports failure
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module wisc_core_tb -f list.f \
	-o wisc_core_sim > build.log 2>&1 \
	&& ./obj_dir/wisc_core_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0
